// File: sources.f
verilog/main_bus_pkg.sv
verilog/cabinet_pkg.sv
verilog/main_addr_decode.sv
verilog/main_dual_ram.sv
verilog/gcu_op_ctrl.sv
verilog/io_read_mux.sv
verilog/snowbro2_main_bus.sv
testbench/tb_main_bus.sv

// File: run_sim.sh
#!/bin/sh
# build the main bus testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_main_bus \
    -Mdir obj_dir -o tb_main_bus_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_main_bus_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// File: testbench/tb_main_bus.sv
// main bus testbench: runs a table of cpu accesses and checks read data, sound, gcu and rom outputs
`timescale 1ns/10ps

module tb_main_bus
    import main_bus_pkg::*;
    import cabinet_pkg::*;
();

    typedef enum logic [2:0] {
        kind_mem,   // cpu_din only
        kind_pal,   // cpu_din and the video read port
        kind_ym,
        kind_oki,
        kind_gcu,
        kind_rom
    } row_kind_t;

    typedef struct packed {
        row_kind_t   kind;
        logic [23:0] addr;    // byte address
        logic        rw;
        logic [1:0]  strb_n;  // {uds_n, lds_n}
        logic [15:0] wdata;   // also the rom word on rom rows
        logic        flag;    // expected ym_wr_cmd on ym rows, set on gcu reads
        cabinet_in_t cab;
        logic [15:0] exp;     // expected cpu_din
    } row_t;

    logic                 CLK96;
    logic                 RESET96;
    cpu_bus_t             bus;
    cabinet_in_t          cab;
    logic                 prg_ok;
    logic [15:0]          prg_data;
    logic                 gcu_ack;
    logic [15:0]          gcu_dout;
    logic [7:0]           ym_dout;
    logic [7:0]           oki_dout;
    logic [PALRAM_AW-1:0] pal_rd_addr;
    logic [15:0]          cpu_din;
    logic                 prg_cs;
    logic [PRG_AW-1:0]    prg_addr;
    gcu_op_t              gcu_op;
    logic                 ym_cs;
    logic                 oki_cs;
    logic                 ym_we;
    logic                 ym_wr_cmd;
    logic                 oki_we_n;
    logic [7:0]           sound_din;
    logic [15:0]          pal_q;
    logic                 bus_busy;

    row_t   rows[$];
    integer seed = 89817;
    int     errors = 0;
    int     cycles = 0;
    int     cycle_limit = 0;

    snowbro2_main_bus dut (.*);

    initial begin
        CLK96 = 1'b0;
        forever #4 CLK96 = ~CLK96;
    end

    always @(posedge CLK96) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input row_kind_t kind, input logic [23:0] addr, input logic rw,
                           input logic [1:0] strb_n, input logic [15:0] wdata,
                           input logic flag, input cabinet_in_t c, input logic [15:0] exp);
        row_t r;
        r.kind   = kind;
        r.addr   = addr;
        r.rw     = rw;
        r.strb_n = strb_n;
        r.wdata  = wdata;
        r.flag   = flag;
        r.cab    = c;
        r.exp    = exp;
        rows.push_back(r);
    endtask

    // cabinet port read at an offset of the i/o page
    task automatic add_io(input cabinet_in_t c, input logic [11:0] ofs, input logic [15:0] exp);
        add_row(kind_mem, 24'h700000 + 24'(ofs), 1'b1, 2'b00, 16'h0000, 1'b0, c, exp);
    endtask

    task automatic build_table();
        logic [15:0] w;
        logic [1:0]  lanes;
        logic [23:0] a;
        logic [15:0] ram_shadow [8];
        logic [15:0] pal_shadow [4];
        cabinet_in_t cab_a;
        cabinet_in_t cab_b;
        cab_a = '{joystick1: 10'h3FE, joystick2: 10'h3EF, joystick3: 10'h3B7,
                  joystick4: 10'h000, start: 4'b1110, coin: 4'b1101, service: 1'b1,
                  test: 1'b0, dip_a: 8'hA5, dip_b: 8'h3C, dip_c: 8'h96};
        cab_b = '{joystick1: 10'h000, joystick2: 10'h3DB, joystick3: 10'h3FF,
                  joystick4: 10'h3BF, start: 4'b0001, coin: 4'b0010, service: 1'b0,
                  test: 1'b1, dip_a: 8'h0F, dip_b: 8'hF0, dip_c: 8'h5A};
        // work ram full words first and then single lanes on every other word
        for (int i = 0; i < 8; i++) begin
            w             = 16'($random(seed));
            a             = 24'h100000 + 24'(i * 32'h2468);
            ram_shadow[i] = w;
            add_row(kind_mem, a, 1'b0, 2'b00, w, 1'b0, cab_a, 16'h0000);
        end
        for (int i = 0; i < 8; i += 2) begin
            w     = 16'($random(seed));
            a     = 24'h100000 + 24'(i * 32'h2468);
            lanes = (i % 4 == 0) ? 2'b10 : 2'b01;  // lower lane only or upper lane only
            if (!lanes[1]) ram_shadow[i][15:8] = w[15:8];
            if (!lanes[0]) ram_shadow[i][7:0] = w[7:0];
            add_row(kind_mem, a, 1'b0, lanes, w, 1'b0, cab_a, 16'h0000);
        end
        for (int i = 0; i < 8; i++) begin
            a = 24'h100000 + 24'(i * 32'h2468);
            add_row(kind_mem, a, 1'b1, 2'b00, 16'h0000, 1'b0, cab_a, ram_shadow[i]);
        end
        // palette read back on both ports
        for (int i = 0; i < 4; i++) begin
            w             = 16'($random(seed));
            pal_shadow[i] = w;
            add_row(kind_mem, 24'h400000 + 24'(i * 32'h3F2), 1'b0, 2'b00, w, 1'b0, cab_a, 16'h0);
        end
        for (int i = 0; i < 4; i++) begin
            a = 24'h400000 + 24'(i * 32'h3F2);
            add_row(kind_pal, a, 1'b1, 2'b00, 16'h0000, 1'b0, cab_a, pal_shadow[i]);
        end
        add_io(cab_a, IO_DSW_C, 16'h9696);
        add_io(cab_a, IO_DSW_A, 16'hA5A5);
        add_io(cab_a, IO_DSW_B, 16'h3C3C);
        add_io(cab_a, IO_IN1, 16'h0808);
        add_io(cab_a, IO_IN2, 16'h1010);
        add_io(cab_a, IO_IN3, 16'h4141);
        add_io(cab_a, IO_IN4, 16'h7F7F);
        add_io(cab_a, IO_SYS, 16'h9634);
        add_io(cab_b, IO_DSW_C, 16'h5A5A);
        add_io(cab_b, IO_DSW_A, 16'h0F0F);
        add_io(cab_b, IO_DSW_B, 16'hF0F0);
        add_io(cab_b, IO_IN1, 16'h3F3F);    // no bit 6 on player 1
        add_io(cab_b, IO_IN2, 16'h2222);
        add_io(cab_b, IO_IN3, 16'h0000);
        add_io(cab_b, IO_IN4, 16'h4040);
        add_io(cab_b, IO_SYS, 16'h5A49);
        add_io(cab_b, 12'h020, 16'h0000);   // unmapped port
        // sound chips sit on the low byte
        add_row(kind_ym, 24'h500000, 1'b0, 2'b10, 16'h0014, 1'b0, cab_a, 16'h0000);
        add_row(kind_ym, 24'h500002, 1'b0, 2'b10, 16'h0033, 1'b1, cab_a, 16'h0000);
        add_row(kind_ym, 24'h500002, 1'b1, 2'b10, 16'h0000, 1'b1, cab_a, 16'hC3C3);
        add_row(kind_oki, 24'h600000, 1'b0, 2'b10, 16'h0088, 1'b0, cab_a, 16'h0000);
        add_row(kind_oki, 24'h600000, 1'b1, 2'b10, 16'h0000, 1'b0, cab_a, 16'h5E5E);
        add_row(kind_gcu, 24'h300008, 1'b0, 2'b00, 16'h00A5, 1'b0, cab_a, 16'h0000);
        add_row(kind_gcu, 24'h300004, 1'b1, 2'b00, 16'h0000, 1'b1, cab_a, 16'h1E2D);
        add_row(kind_rom, 24'h012346, 1'b1, 2'b00, 16'hBEEF, 1'b0, cab_a, 16'hBEEF);
        add_row(kind_rom, 24'h07FFFE, 1'b1, 2'b00, 16'h1234, 1'b0, cab_a, 16'h1234);
    endtask

    // one access with as_n low for 4 clocks and checks in cycles 1 to 3
    task automatic run_access(input row_t r);
        @(posedge CLK96);
        bus.addr    <= r.addr[23:1];
        bus.rw      <= r.rw;
        bus.as_n    <= 1'b0;
        bus.uds_n   <= r.strb_n[1];
        bus.lds_n   <= r.strb_n[0];
        bus.dout    <= r.wdata;
        cab         <= r.cab;
        prg_data    <= r.wdata;
        prg_ok      <= r.kind != kind_rom;   // rom starts out not ready
        pal_rd_addr <= r.addr[PALRAM_AW:1];
        @(posedge CLK96);
        @(negedge CLK96);
        if (r.kind == kind_rom) begin
            compare_value("prg_cs", 32'(prg_cs), 32'd1);
            compare_value("prg_addr", 32'(prg_addr), 32'(r.addr[PRG_AW:1]));
            compare_value("bus_busy while rom not ready", 32'(bus_busy), 32'd1);
        end
        @(posedge CLK96);
        prg_ok <= 1'b1;
        @(negedge CLK96);
        compare_value($sformatf("cpu_din at %h", r.addr), 32'(cpu_din), 32'(r.exp));
        case (r.kind)
            kind_pal: compare_value("pal_q", 32'(pal_q), 32'(r.exp));
            kind_ym: begin
                compare_value("ym_cs", 32'(ym_cs), 32'd1);
                compare_value("ym_we", 32'(ym_we), 32'(r.rw));
                compare_value("ym_wr_cmd", 32'(ym_wr_cmd), 32'(r.flag));
                if (!r.rw) compare_value("sound_din", 32'(sound_din), 32'(r.wdata[7:0]));
            end
            kind_oki: begin
                compare_value("oki_cs", 32'(oki_cs), 32'd1);
                compare_value("oki_we_n", 32'(oki_we_n), 32'(r.rw));
            end
            kind_gcu: begin
                if (r.flag) compare_value("read_ram_h", 32'(gcu_op.read_ram_h), 32'd1);
                else compare_value("select_reg", 32'(gcu_op.select_reg), 32'd1);
                compare_value("bus_busy before gcu_ack", 32'(bus_busy), 32'd1);
            end
            kind_rom: compare_value("bus_busy with prg_ok", 32'(bus_busy), 32'd0);
            default: ;
        endcase
        @(posedge CLK96);
        if (r.kind == kind_gcu) gcu_ack <= 1'b1;   // ack while the gcu is still selected
        @(negedge CLK96);
        if (r.kind == kind_gcu) compare_value("bus_busy with gcu_ack", 32'(bus_busy), 32'd0);
        @(posedge CLK96);
        gcu_ack  <= 1'b0;
        bus.as_n <= 1'b1;
    endtask

    // op bits survive an ack during the access and drop on the first ack after it
    task automatic ack_gcu();
        @(negedge CLK96);
        compare_value("gcu op kept through ack in access", 32'(gcu_op != '0), 32'd1);
        @(posedge CLK96);   // selects clear here
        @(posedge CLK96);
        @(negedge CLK96);
        compare_value("gcu op held after access", 32'(gcu_op != '0), 32'd1);
        @(posedge CLK96);
        gcu_ack <= 1'b1;
        @(posedge CLK96);
        gcu_ack <= 1'b0;
        @(negedge CLK96);
        compare_value("gcu op after ack", 32'(gcu_op), 32'd0);
    endtask

    initial begin
        RESET96     = 1'b1;
        bus         = '0;
        bus.rw      = 1'b1;
        bus.as_n    = 1'b1;
        bus.uds_n   = 1'b1;
        bus.lds_n   = 1'b1;
        cab         = '1;         // nothing pressed
        prg_ok      = 1'b0;
        prg_data    = '0;
        gcu_ack     = 1'b0;
        gcu_dout    = 16'h1E2D;
        ym_dout     = 8'hC3;
        oki_dout    = 8'h5E;
        pal_rd_addr = '0;
        build_table();
        cycle_limit = rows.size() * 6 + 200;
        repeat (2) @(posedge CLK96);
        RESET96 <= 1'b0;
        @(negedge CLK96);
        compare_value("cpu_din after reset", 32'(cpu_din), 32'd0);
        compare_value("gcu_op after reset", 32'(gcu_op), 32'd0);
        compare_value("prg_addr after reset", 32'(prg_addr), 32'd0);
        compare_value("selects after reset", 32'({prg_cs, ym_cs, oki_cs}), 32'd0);
        foreach (rows[i]) begin
            run_access(rows[i]);
            if (rows[i].kind == kind_gcu) ack_gcu();
        end
        repeat (2) @(posedge CLK96);
        $display("%0d errors in %0d table rows", errors, rows.size());
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/snowbro2_main_bus.sv
// snowbro2 main bus glue: decoder, work and palette ram, gcu strobes, sound selects and read mux
`timescale 1ns/10ps

module snowbro2_main_bus
    import main_bus_pkg::*;
    import cabinet_pkg::*;
(
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  cpu_bus_t             bus,
    input  cabinet_in_t          cab,
    input  logic                 prg_ok,
    input  logic [15:0]          prg_data,
    input  logic                 gcu_ack,
    input  logic [15:0]          gcu_dout,
    input  logic [7:0]           ym_dout,
    input  logic [7:0]           oki_dout,
    input  logic [PALRAM_AW-1:0] pal_rd_addr,
    output logic [15:0]          cpu_din,
    output logic                 prg_cs,
    output logic [PRG_AW-1:0]    prg_addr,
    output gcu_op_t              gcu_op,
    output logic                 ym_cs,
    output logic                 oki_cs,
    output logic                 ym_we,
    output logic                 ym_wr_cmd,
    output logic                 oki_we_n,
    output logic [7:0]           sound_din,
    output logic [15:0]          pal_q,
    output logic                 bus_busy
);

    bus_sel_t    sel;
    logic        cpu_wr;
    logic [1:0]  ram_we;
    logic [1:0]  pal_we;
    logic [15:0] ram_q;
    logic [15:0] pal_cpu_q;

    main_addr_decode u_decode (
        .CLK96(CLK96), .RESET96(RESET96), .bus(bus), .sel(sel), .prg_addr(prg_addr)
    );

    assign cpu_wr = ~bus.rw;
    assign ram_we = {sel.ram & cpu_wr & ~bus.uds_n, sel.ram & cpu_wr & ~bus.lds_n};
    assign pal_we = {sel.palram & cpu_wr & ~bus.uds_n, sel.palram & cpu_wr & ~bus.lds_n};

    // work ram 0x100000-0x10FFFF, video side not wired on this board
    main_dual_ram #(.aw(RAM_AW)) u_work_ram (
        .CLK96(CLK96), .we(ram_we),
        .cpu_addr(bus.addr[RAM_AW-1:0]), .cpu_din(bus.dout), .cpu_q(ram_q),
        .vid_addr(bus.addr[RAM_AW-1:0]), .vid_q()
    );

    // palette 0x400000-0x400FFF, second port feeds the video side
    main_dual_ram #(.aw(PALRAM_AW)) u_pal_ram (
        .CLK96(CLK96), .we(pal_we),
        .cpu_addr(bus.addr[PALRAM_AW-1:0]), .cpu_din(bus.dout), .cpu_q(pal_cpu_q),
        .vid_addr(pal_rd_addr), .vid_q(pal_q)
    );

    gcu_op_ctrl u_gcu_ctrl (
        .CLK96(CLK96), .RESET96(RESET96), .bus(bus), .sel(sel),
        .gcu_ack(gcu_ack), .op(gcu_op)
    );

    io_read_mux u_read_mux (
        .CLK96(CLK96), .RESET96(RESET96), .bus(bus), .sel(sel), .cab(cab),
        .gcu_dout(gcu_dout), .prg_data(prg_data), .ram_q(ram_q), .pal_q(pal_cpu_q),
        .ym_dout(ym_dout), .oki_dout(oki_dout), .cpu_din(cpu_din)
    );

    assign prg_cs    = sel.rom;
    assign ym_cs     = sel.ym2151;
    assign oki_cs    = sel.oki;
    assign ym_we     = bus.rw;
    assign ym_wr_cmd = {bus.addr[6:0], 1'b0} == 8'h02;  // 0 = register select, 1 = data
    assign oki_we_n  = ~(sel.oki & cpu_wr);
    assign sound_din = bus.dout[7:0];                   // both chips sit on the low byte

    // back-pressure for the external dtack logic
    assign bus_busy = (sel.rom & ~prg_ok) | (sel.gcu & ~gcu_ack);

endmodule

// File: verilog/io_read_mux.sv
// cpu read mux: builds cabinet and sound words and registers the read data by priority
`timescale 1ns/10ps

module io_read_mux
    import main_bus_pkg::*;
    import cabinet_pkg::*;
(
    input  logic        CLK96,
    input  logic        RESET96,
    input  cpu_bus_t    bus,
    input  bus_sel_t    sel,
    input  cabinet_in_t cab,
    input  logic [15:0] gcu_dout,
    input  logic [15:0] prg_data,
    input  logic [15:0] ram_q,
    input  logic [15:0] pal_q,
    input  logic [7:0]  ym_dout,
    input  logic [7:0]  oki_dout,
    output logic [15:0] cpu_din
);

    logic [11:0] io_ofs;
    logic        io_hit;
    logic [15:0] io_word;
    logic [15:0] next_din;

    // cabinet is active low, the game wants active high
    function automatic logic [7:0] player_byte(input logic [9:0] joy, input logic has_b6);
        logic [7:0] b;
        b    = '0;
        b[0] = ~joy[3];
        b[1] = ~joy[2];
        b[2] = ~joy[1];
        b[3] = ~joy[0];
        b[4] = ~joy[4];
        b[5] = ~joy[5];
        b[6] = has_b6 & ~joy[6];  // third button only on players 3 and 4
        return b;
    endfunction

    assign io_ofs = {bus.addr[10:0], 1'b0};

    always_comb begin
        io_hit  = sel.io & bus.rw;
        io_word = '0;
        case (io_ofs)
            IO_IN1:   io_word = {2{player_byte(cab.joystick1, 1'b0)}};
            IO_IN2:   io_word = {2{player_byte(cab.joystick2, 1'b0)}};
            IO_IN3:   io_word = {2{player_byte(cab.joystick3, 1'b1)}};
            IO_IN4:   io_word = {2{player_byte(cab.joystick4, 1'b1)}};
            IO_SYS:   io_word = {cab.dip_c, 1'b0, ~cab.start[1], ~cab.start[0],
                                 ~cab.coin[1], ~cab.coin[0], ~cab.test, 1'b0, ~cab.service};
            IO_DSW_A: io_word = {2{cab.dip_a}};
            IO_DSW_B: io_word = {2{cab.dip_b}};
            IO_DSW_C: io_word = {2{cab.dip_c}};
            default:  io_hit  = 1'b0;  // unmapped port reads as zero
        endcase
    end

    always_comb begin
        if (sel.gcu && bus.rw)         next_din = gcu_dout;
        else if (sel.rom)              next_din = prg_data;
        else if (sel.ram && bus.rw)    next_din = ram_q;
        else if (sel.palram && bus.rw) next_din = pal_q;
        else if (io_hit)               next_din = io_word;
        else if (sel.oki && bus.rw)    next_din = {2{oki_dout}};
        else if (sel.ym2151 && bus.rw) next_din = {2{ym_dout}};
        else                           next_din = '0;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) cpu_din <= '0;
        else         cpu_din <= next_din;
    end

endmodule

// File: verilog/gcu_op_ctrl.sv
// gcu operation control: turns register accesses into strobes held until the gcu acknowledges
`timescale 1ns/10ps

module gcu_op_ctrl
    import main_bus_pkg::*;
(
    input  logic     CLK96,
    input  logic     RESET96,
    input  cpu_bus_t bus,
    input  bus_sel_t sel,
    input  logic     gcu_ack,
    output gcu_op_t  op
);

    logic [3:0] reg_ofs;

    assign reg_ofs = {bus.addr[2:0], 1'b0};  // byte offset in the gcu page

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            op <= '0;
        end else if (sel.gcu) begin
            if (bus.rw) begin
                case (reg_ofs)
                    GCU_OFS_DATA_H: op.read_ram_h <= 1'b1;
                    GCU_OFS_DATA_L: op.read_ram_l <= 1'b1;
                    default: ;
                endcase
            end else begin
                case (reg_ofs)
                    GCU_OFS_PTR:    op.set_ram_ptr <= 1'b1;
                    GCU_OFS_SELECT: op.select_reg  <= 1'b1;
                    GCU_OFS_WRITE:  op.write_reg   <= 1'b1;
                    GCU_OFS_DATA_H,
                    GCU_OFS_DATA_L: op.write_ram   <= 1'b1;  // either half of the data port
                    default: ;
                endcase
            end
        end else if (gcu_ack) begin
            // ack only counts once the cpu has left the gcu page
            op <= '0;
        end
    end

    // a new request can only come from a decoded gcu access the cycle before
    a_op_from_access: assert property (
        @(posedge CLK96) disable iff (RESET96)
        (|(op & ~$past(op))) |-> $past(sel.gcu)
    ) else $error("gcu op raised without a gcu access");

endmodule

// File: verilog/main_dual_ram.sv
// dual-port word ram: byte-lane writes and reads on the cpu side, read only on the video side
`timescale 1ns/10ps

module main_dual_ram
    import main_bus_pkg::*;
#(
    parameter int aw = RAM_AW
) (
    input  logic          CLK96,
    input  logic [1:0]    we,        // {upper, lower} lane
    input  logic [aw-1:0] cpu_addr,
    input  logic [15:0]   cpu_din,
    output logic [15:0]   cpu_q,
    input  logic [aw-1:0] vid_addr,
    output logic [15:0]   vid_q
);

    logic [15:0] mem [2**aw];

    always_ff @(posedge CLK96) begin
        if (we[1]) mem[cpu_addr][15:8] <= cpu_din[15:8];
        if (we[0]) mem[cpu_addr][7:0]  <= cpu_din[7:0];
        cpu_q <= mem[cpu_addr];  // old word on a write cycle
    end

    // second port never writes
    always_ff @(posedge CLK96) begin
        vid_q <= mem[vid_addr];
    end

    a_write_addr_known: assert property (
        @(posedge CLK96) (|we) |-> !$isunknown(cpu_addr)
    ) else $error("lane write with unknown address");

endmodule

// File: verilog/main_addr_decode.sv
// main address decoder: registers one chip select per region while the address strobe is low
`timescale 1ns/10ps

module main_addr_decode
    import main_bus_pkg::*;
(
    input  logic              CLK96,
    input  logic              RESET96,
    input  cpu_bus_t          bus,
    output bus_sel_t          sel,
    output logic [PRG_AW-1:0] prg_addr
);

    logic [23:0] byte_addr;
    bus_sel_t    next_sel;

    // byte view keeps the compares readable against the memory map
    assign byte_addr = {bus.addr, 1'b0};

    always_comb begin
        next_sel        = '0;
        next_sel.rom    = byte_addr <= ROM_LIMIT;
        next_sel.ram    = byte_addr[23:16] == RAM_PAGE;
        next_sel.gcu    = byte_addr[23:20] == GCU_NIBBLE;
        next_sel.palram = byte_addr[23:20] == PALRAM_NIBBLE;  // direct palette access
        next_sel.ym2151 = byte_addr[23:8] == YM2151_PAGE;
        next_sel.oki    = byte_addr[23:8] == OKI_PAGE;
        next_sel.io     = byte_addr[23:12] == IO_PAGE;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel      <= '0;
            prg_addr <= '0;
        end else if (!bus.as_n) begin
            sel      <= next_sel;
            prg_addr <= bus.addr[PRG_AW-1:0];  // rom word address, latched with the select
        end else begin
            sel <= '0;  // drop everything between cycles
        end
    end

    // regions must never overlap, whatever the address
    a_one_select: assert property (
        @(posedge CLK96) disable iff (RESET96) $onehot0(sel)
    ) else $error("more than one chip select active: %b", sel);

endmodule

// File: verilog/cabinet_pkg.sv
// cabinet package: player, coin, system and dip inputs plus the i/o page offsets
package cabinet_pkg;

    // everything here arrives active low from the cabinet side
    typedef struct packed {
        logic [9:0] joystick1;
        logic [9:0] joystick2;
        logic [9:0] joystick3;
        logic [9:0] joystick4;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic       test;
        logic [7:0] dip_a;   // dips go to the cpu as they are
        logic [7:0] dip_b;
        logic [7:0] dip_c;
    } cabinet_in_t;

    // byte offsets inside the 0x700xxx page
    localparam logic [11:0] IO_DSW_C = 12'h000;  // jumper block
    localparam logic [11:0] IO_DSW_A = 12'h004;
    localparam logic [11:0] IO_DSW_B = 12'h008;
    localparam logic [11:0] IO_IN1   = 12'h00C;
    localparam logic [11:0] IO_IN2   = 12'h010;
    localparam logic [11:0] IO_IN3   = 12'h014;
    localparam logic [11:0] IO_IN4   = 12'h018;
    localparam logic [11:0] IO_SYS   = 12'h01C;

endpackage

// File: verilog/main_bus_pkg.sv
// main cpu bus package: memory map, bus and chip-select types for the snowbro2 glue
package main_bus_pkg;

    // cpu bus as the glue sees it, addr is a 68000 word address (A23..A1)
    typedef struct packed {
        logic [22:0] addr;
        logic        rw;      // 1 = read
        logic        as_n;
        logic        uds_n;
        logic        lds_n;
        logic [15:0] dout;    // cpu write data
    } cpu_bus_t;

    // one registered select per region
    typedef struct packed {
        logic rom;
        logic ram;
        logic palram;
        logic gcu;
        logic io;
        logic ym2151;
        logic oki;
    } bus_sel_t;

    // region matches, compared against the byte address
    localparam logic [23:0] ROM_LIMIT     = 24'h07FFFF;  // 0x000000-0x07FFFF
    localparam logic [7:0]  RAM_PAGE      = 8'h10;       // 0x10xxxx
    localparam logic [3:0]  GCU_NIBBLE    = 4'h3;        // 0x3xxxxx
    localparam logic [3:0]  PALRAM_NIBBLE = 4'h4;        // 0x4xxxxx
    localparam logic [15:0] YM2151_PAGE   = 16'h5000;    // 0x5000xx
    localparam logic [15:0] OKI_PAGE      = 16'h6000;    // 0x6000xx
    localparam logic [11:0] IO_PAGE       = 12'h700;     // 0x700xxx

    // address widths, all in 16-bit words
    localparam int RAM_AW    = 15;   // 32K words of work ram
    localparam int PALRAM_AW = 11;   // 2K words of palette
    localparam int PRG_AW    = 19;

    // gcu register byte offsets within its page
    localparam logic [3:0] GCU_OFS_PTR    = 4'h0;
    localparam logic [3:0] GCU_OFS_DATA_H = 4'h4;
    localparam logic [3:0] GCU_OFS_DATA_L = 4'h6;
    localparam logic [3:0] GCU_OFS_SELECT = 4'h8;
    localparam logic [3:0] GCU_OFS_WRITE  = 4'hC;

    // operation requests towards the gcu, each held until it acknowledges
    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } gcu_op_t;

endpackage
